// ==== design/alu_unit.sv ====
// Combinational RV32 integer ALU
`timescale 1ns/100ps
`include "core_config.svh"

module alu_unit (
	input core_pkg::alu_op_t op,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result
);
	import core_pkg::*;

	logic [4:0] shamt;
	logic lt_signed;
	logic lt_unsigned;

	// Only the low five bits of b shift
	assign shamt = b[4:0];
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			ADD: result = a + b;
			SUB: result = a - b;
			AND: result = a & b;
			OR: result = a | b;
			XOR: result = a ^ b;
			SLL: result = a << shamt;
			SRL: result = a >> shamt;
			// Arithmetic shift keeps the sign
			SRA: result = $unsigned($signed(a) >>> shamt);
			// Compares return zero or one
			SLT: result = {{(`XLEN-1){1'b0}}, lt_signed};
			SLTU: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
			default: result = '0;
		endcase
	end

endmodule

// ==== design/core_pkg.sv ====
// Opcode, unit, memory size and writeback select enums; stage structs
`include "core_config.svh"

package core_pkg;

	// ALU operations
	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU
	} alu_op_t;

	// Divider operations
	typedef enum logic [1:0] {
		DIV, DIVU, REM, REMU
	} div_op_t;

	// Which execute unit handles the op
	typedef enum logic {
		UNIT_ALU, UNIT_DIV
	} unit_t;

	// Access size, funct3 encoding
	// Stores use LB, LH and LW for byte, half and word
	typedef enum logic [2:0] {
		LB = 3'd0, LH = 3'd1, LW = 3'd2, LBU = 3'd4, LHU = 3'd5
	} mem_size_t;

	// Writeback source
	typedef enum logic [1:0] {
		WB_EXE, WB_MEM, WB_IMM, WB_PC4
	} wb_sel_t;

	// Decoded micro-op entering execute
	typedef struct packed {
		unit_t unit;
		alu_op_t alu_op;
		div_op_t div_op;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] store_data;
		logic [`XLEN-1:0] imm;
		logic [`XLEN-1:0] pc4;
		logic [`REG_BITS-1:0] rd;
		logic wr_en;
		logic mem_write;
		logic mem_read;
		mem_size_t mem_size;
		wb_sel_t wb_sel;
	} exe_uop_t;

	// EXE/MEM register contents
	typedef struct packed {
		logic [`XLEN-1:0] result;
		logic [`XLEN-1:0] store_data;
		logic [`XLEN-1:0] imm;
		logic [`XLEN-1:0] pc4;
		logic [`REG_BITS-1:0] rd;
		logic wr_en;
		logic [3:0] byte_en;
		logic mem_read;
		mem_size_t mem_size;
		wb_sel_t wb_sel;
	} exe_mem_t;

	// Writeback to the register file
	typedef struct packed {
		logic [`REG_BITS-1:0] rd;
		logic [`XLEN-1:0] data;
	} wb_t;

endpackage

// ==== design/div_unit.sv ====
// Iterative radix-2 restoring divider with RV32 signed and unsigned results
`timescale 1ns/100ps
`include "core_config.svh"

module div_unit (
	input logic clk,
	input logic rst,
	input logic abort,
	input logic req_valid,
	output logic req_ready,
	input core_pkg::div_op_t op,
	input logic [`XLEN-1:0] dividend,
	input logic [`XLEN-1:0] divisor,
	output logic done,
	output logic [`XLEN-1:0] result
);
	import core_pkg::*;

	localparam int CNT_W = $clog2(`DIV_STEPS);

	typedef enum logic [1:0] {IDLE, RUN, FIX} state_t;

	state_t state;
	logic [CNT_W-1:0] count;
	// Quotient register also shifts the dividend out
	logic [`XLEN-1:0] quot;
	logic [`XLEN-1:0] rem;
	logic [`XLEN-1:0] dvs;
	logic neg_q;
	logic neg_r;
	logic div_zero;
	logic want_rem;
	logic is_signed;
	logic start;
	logic [`XLEN-1:0] mag_a;
	logic [`XLEN-1:0] mag_b;
	logic [`XLEN:0] rem_shift;
	logic [`XLEN:0] diff;

	assign req_ready = (state == IDLE);
	assign done = (state == FIX);
	assign start = req_valid & req_ready;

	// Magnitudes of the request operands
	assign is_signed = (op == DIV) || (op == REM);
	assign mag_a = (is_signed && dividend[`XLEN-1]) ? -dividend : dividend;
	assign mag_b = (is_signed && divisor[`XLEN-1]) ? -divisor : divisor;

	// One restoring step
	assign rem_shift = {rem, quot[`XLEN-1]};
	assign diff = rem_shift - {1'b0, dvs};

	always_ff @(posedge clk) begin
		if (rst || abort) begin
			state <= IDLE;
			count <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= RUN;
						count <= '0;
					end
				end
				RUN: begin
					count <= count + 1'b1;
					if (count == CNT_W'(`DIV_STEPS - 1))
						state <= FIX;
				end
				FIX: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			quot <= mag_a;
			rem <= '0;
			dvs <= mag_b;
			neg_q <= is_signed & (dividend[`XLEN-1] ^ divisor[`XLEN-1]);
			// Remainder takes the dividend's sign
			neg_r <= is_signed & dividend[`XLEN-1];
			div_zero <= (divisor == '0);
			want_rem <= (op == REM) || (op == REMU);
		end else if (state == RUN) begin
			// Subtract fits, so keep it and shift in a one
			if (!diff[`XLEN]) begin
				rem <= diff[`XLEN-1:0];
				quot <= {quot[`XLEN-2:0], 1'b1};
			end else begin
				rem <= rem_shift[`XLEN-1:0];
				quot <= {quot[`XLEN-2:0], 1'b0};
			end
		end
	end

	// Sign fix in the FIX cycle
	// Divide by zero leaves the dividend magnitude as remainder
	// Overflow gives 2^31 negated, which is the most negative value again
	always_comb begin
		if (want_rem)
			result = neg_r ? -rem : rem;
		else if (div_zero)
			result = '1;
		else
			result = neg_q ? -quot : quot;
	end

endmodule

// ==== design/exe_mem_top.sv ====
// Top level joining execute, EXE/MEM register and memory stage
`timescale 1ns/100ps
`include "core_config.svh"

module exe_mem_top (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic in_valid,
	output logic in_ready,
	input core_pkg::exe_uop_t in_uop,
	output logic wb_valid,
	output core_pkg::wb_t wb
);
	import core_pkg::*;

	exe_mem_t exe_out;
	exe_mem_t mem_in;
	logic stall;
	logic bubble;

	exe_stage exe_i (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_uop(in_uop),
		.exe_out(exe_out),
		.stall(stall),
		.bubble(bubble)
	);

	pipereg_exe_mem pipereg_i (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.stall(stall),
		.bubble(bubble),
		.exe_in(exe_out),
		.mem_out(mem_in)
	);

	// No back-pressure on writeback
	mem_stage mem_i (
		.clk(clk),
		.rst(rst),
		.mem_in(mem_in),
		.wb_valid(wb_valid),
		.wb(wb)
	);

endmodule

// ==== design/exe_stage.sv ====
// Execute stage: ALU and divider issue, byte enables, result select, stall and bubble
`timescale 1ns/100ps
`include "core_config.svh"

module exe_stage (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic in_valid,
	output logic in_ready,
	input core_pkg::exe_uop_t in_uop,
	output core_pkg::exe_mem_t exe_out,
	output logic stall,
	output logic bubble
);
	import core_pkg::*;

	logic [`XLEN-1:0] alu_result;
	logic [`XLEN-1:0] div_result;
	logic div_req_valid;
	logic div_req_ready;
	logic div_done;
	// Divide in flight
	logic busy;
	logic fire;
	logic fire_alu;
	logic fire_div;
	logic [3:0] byte_en;
	exe_mem_t issue;
	exe_mem_t held;

	alu_unit alu_i (
		.op(in_uop.alu_op),
		.a(in_uop.a),
		.b(in_uop.b),
		.result(alu_result)
	);

	div_unit div_i (
		.clk(clk),
		.rst(rst),
		.abort(flush),
		.req_valid(div_req_valid),
		.req_ready(div_req_ready),
		.op(in_uop.div_op),
		.dividend(in_uop.a),
		.divisor(in_uop.b),
		.done(div_done),
		.result(div_result)
	);

	// One op in execute at a time
	assign in_ready = ~busy & div_req_ready;
	// Flush drops the op offered this cycle
	assign fire = in_valid & in_ready & ~flush;
	assign fire_alu = fire & (in_uop.unit == UNIT_ALU);
	assign fire_div = fire & (in_uop.unit == UNIT_DIV);
	assign div_req_valid = in_valid & ~busy & ~flush & (in_uop.unit == UNIT_DIV);

	// Store byte lanes from size and address offset
	always_comb begin
		byte_en = 4'b0000;
		if (in_uop.mem_write) begin
			case (in_uop.mem_size)
				LB, LBU: byte_en = 4'b0001 << alu_result[1:0];
				LH, LHU: byte_en = alu_result[1] ? 4'b1100 : 4'b0011;
				default: byte_en = 4'b1111;
			endcase
		end
	end

	always_comb begin
		issue.result = alu_result;
		issue.store_data = in_uop.store_data;
		issue.imm = in_uop.imm;
		issue.pc4 = in_uop.pc4;
		issue.rd = in_uop.rd;
		issue.wr_en = in_uop.wr_en;
		issue.byte_en = byte_en;
		issue.mem_read = in_uop.mem_read;
		issue.mem_size = in_uop.mem_size;
		issue.wb_sel = in_uop.wb_sel;
	end

	// Control fields of the divide wait here
	always_ff @(posedge clk) begin
		if (fire_div)
			held <= issue;
	end

	always_ff @(posedge clk) begin
		if (rst || flush)
			busy <= 1'b0;
		else if (fire_div)
			busy <= 1'b1;
		else if (div_done)
			busy <= 1'b0;
	end

	// Divider result replaces the ALU value while busy
	always_comb begin
		exe_out = issue;
		if (busy) begin
			exe_out = held;
			exe_out.result = div_result;
		end
	end

	// Hold the register until div_done
	assign stall = busy & ~div_done;
	// Idle cycles and divide acceptance load a bubble
	assign bubble = ~busy & ~fire_alu;

endmodule

// ==== design/mem_stage.sv ====
// Memory stage: byte-enabled data memory, load extension, registered writeback
`timescale 1ns/100ps
`include "core_config.svh"

module mem_stage (
	input logic clk,
	input logic rst,
	input core_pkg::exe_mem_t mem_in,
	output logic wb_valid,
	output core_pkg::wb_t wb
);
	import core_pkg::*;

	localparam int AW = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] dmem [`DMEM_WORDS];
	logic [AW-1:0] idx;
	logic [`XLEN-1:0] rd_word;
	logic [7:0] ld_byte;
	logic [15:0] ld_half;
	logic [`XLEN-1:0] ld_ext;
	logic [`XLEN-1:0] ld_data;
	logic [`XLEN-1:0] st_lanes;
	logic [`XLEN-1:0] wb_data;

	// Word index above the byte offset
	assign idx = mem_in.result[2 +: AW];
	assign rd_word = dmem[idx];

	// Store data copied into every lane
	always_comb begin
		case (mem_in.mem_size)
			LB, LBU: st_lanes = {(`XLEN/8){mem_in.store_data[7:0]}};
			LH, LHU: st_lanes = {(`XLEN/16){mem_in.store_data[15:0]}};
			default: st_lanes = mem_in.store_data;
		endcase
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `XLEN/8; i++) begin
			if (mem_in.byte_en[i])
				dmem[idx][8*i +: 8] <= st_lanes[8*i +: 8];
		end
	end

	// Load slice by offset
	assign ld_byte = rd_word[8*mem_in.result[1:0] +: 8];
	assign ld_half = mem_in.result[1] ? rd_word[31:16] : rd_word[15:0];

	always_comb begin
		case (mem_in.mem_size)
			LB: ld_ext = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
			LBU: ld_ext = {{(`XLEN-8){1'b0}}, ld_byte};
			LH: ld_ext = {{(`XLEN-16){ld_half[15]}}, ld_half};
			LHU: ld_ext = {{(`XLEN-16){1'b0}}, ld_half};
			default: ld_ext = rd_word;
		endcase
	end

	// Non-loads read back zero
	assign ld_data = mem_in.mem_read ? ld_ext : '0;

	always_comb begin
		case (mem_in.wb_sel)
			WB_MEM: wb_data = ld_data;
			WB_IMM: wb_data = mem_in.imm;
			WB_PC4: wb_data = mem_in.pc4;
			default: wb_data = mem_in.result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			wb_valid <= 1'b0;
		else
			wb_valid <= mem_in.wr_en;
	end

	always_ff @(posedge clk) begin
		wb.rd <= mem_in.rd;
		wb.data <= wb_data;
	end

endmodule

// ==== design/pipereg_exe_mem.sv ====
// EXE/MEM pipeline register with reset, flush, stall and bubble insert
`timescale 1ns/100ps
`include "core_config.svh"

module pipereg_exe_mem (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic stall,
	input logic bubble,
	input core_pkg::exe_mem_t exe_in,
	output core_pkg::exe_mem_t mem_out
);
	import core_pkg::*;

	exe_mem_t entry;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			entry <= '0;
		end else if (!stall) begin
			entry <= exe_in;
			// Bubble keeps no register write and no store
			if (bubble) begin
				entry.wr_en <= 1'b0;
				entry.byte_en <= 4'b0000;
			end
		end
	end

	// Flush also squashes the entry now in memory
	always_comb begin
		mem_out = entry;
		if (flush) begin
			mem_out.wr_en = 1'b0;
			mem_out.byte_en = 4'b0000;
		end
	end

endmodule

// ==== files.f ====
+incdir+include
design/core_pkg.sv
design/alu_unit.sv
design/div_unit.sv
design/exe_stage.sv
design/pipereg_exe_mem.sv
design/mem_stage.sv
design/exe_mem_top.sv
verification/exe_mem_tb.sv

// ==== include/core_config.svh ====
// Core width, register index, data memory depth and divider step count macros
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data word width in bits
`define XLEN 32

// Register index width
`define REG_BITS 5

// Data memory depth in words
// Index comes from the result bits just above the byte offset
`define DMEM_WORDS 64

// One restoring step per quotient bit
`define DIV_STEPS `XLEN

`endif

// ==== verification/exe_mem_tb.sv ====
// Testbench with clock, reset, stimulus table, writeback monitor, check task and timeouts
`timescale 1ns/100ps
`include "core_config.svh"

module exe_mem_tb;
	import core_pkg::*;

	localparam int WAIT_LIMIT = 4 * `DIV_STEPS;

	// One table entry and its expected writeback
	typedef struct {
		exe_uop_t uop;
		bit wb_exp;
		logic [`REG_BITS-1:0] rd;
		logic [`XLEN-1:0] data;
		bit chain;
		bit flush_op;
	} row_t;

	// Writeback still outstanding
	typedef struct {
		logic [`REG_BITS-1:0] rd;
		logic [`XLEN-1:0] data;
		bit lat_chk;
		int acc;
	} pend_t;

	logic clk;
	logic rst;
	logic flush;
	logic in_valid;
	logic in_ready;
	exe_uop_t in_uop;
	logic wb_valid;
	wb_t wb;
	row_t rows[$];
	pend_t pend_q[$];
	int cycle;

	exe_mem_top dut_i (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_uop(in_uop),
		.wb_valid(wb_valid),
		.wb(wb)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst)
			cycle <= 0;
		else
			cycle <= cycle + 1;
	end

	task automatic stop_failed();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			$display("ERR %s: actual 0x%h expected 0x%h", name, act, exp);
			stop_failed();
		end
	endtask

	// Advance n edges, landing just after the last one
	task automatic step(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// RV32 reference results
	function automatic logic [31:0] alu_model(alu_op_t op, logic [31:0] a, logic [31:0] b);
		int sa;
		int sb;
		sa = a;
		sb = b;
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR: return a | b;
			XOR: return a ^ b;
			SLL: return a << b[4:0];
			SRL: return a >> b[4:0];
			SRA: return sa >>> b[4:0];
			SLT: return (sa < sb) ? 32'd1 : 32'd0;
			SLTU: return (a < b) ? 32'd1 : 32'd0;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] div_model(div_op_t op, logic [31:0] a, logic [31:0] b);
		int sa;
		int sb;
		logic [31:0] q;
		logic [31:0] r;
		sa = a;
		sb = b;
		if (b == 32'd0) begin
			q = '1;
			r = a;
		end else if (op == DIV || op == REM) begin
			// Signed overflow case
			if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
				q = a;
				r = 32'd0;
			end else begin
				q = sa / sb;
				r = sa % sb;
			end
		end else begin
			q = a / b;
			r = a % b;
		end
		return (op == REM || op == REMU) ? r : q;
	endfunction

	// Byte or half sliced out of a stored word
	function automatic logic [31:0] load_model(mem_size_t sz, logic [31:0] w, logic [1:0] off);
		logic [7:0] by;
		logic [15:0] hw;
		by = w[8*off +: 8];
		hw = off[1] ? w[31:16] : w[15:0];
		case (sz)
			LB: return {{24{by[7]}}, by};
			LBU: return {24'd0, by};
			LH: return {{16{hw[15]}}, hw};
			LHU: return {16'd0, hw};
			default: return w;
		endcase
	endfunction

	function automatic exe_uop_t make_uop(unit_t unit, logic [31:0] a, logic [31:0] b,
		logic [4:0] rd);
		exe_uop_t u;
		u = '0;
		u.unit = unit;
		u.a = a;
		u.b = b;
		u.rd = rd;
		u.wr_en = 1'b1;
		u.mem_size = LW;
		u.wb_sel = WB_EXE;
		return u;
	endfunction

	task automatic add_row(input exe_uop_t u, input bit wb_exp, input logic [31:0] data,
		input bit chain, input bit flush_op);
		row_t r;
		r.uop = u;
		r.wb_exp = wb_exp;
		r.rd = u.rd;
		r.data = data;
		r.chain = chain;
		r.flush_op = flush_op;
		rows.push_back(r);
	endtask

	task automatic add_alu(input alu_op_t op, input logic [31:0] a, input logic [31:0] b,
		input logic [4:0] rd);
		exe_uop_t u;
		u = make_uop(UNIT_ALU, a, b, rd);
		u.alu_op = op;
		add_row(u, 1'b1, alu_model(op, a, b), 1'b0, 1'b0);
	endtask

	// Chain keeps the next row waiting behind the divide
	task automatic add_div(input div_op_t op, input logic [31:0] a, input logic [31:0] b,
		input logic [4:0] rd, input bit chain, input bit flush_op);
		exe_uop_t u;
		u = make_uop(UNIT_DIV, a, b, rd);
		u.div_op = op;
		add_row(u, !flush_op, div_model(op, a, b), chain, flush_op);
	endtask

	task automatic add_store(input mem_size_t sz, input logic [31:0] base,
		input logic [31:0] off, input logic [31:0] data);
		exe_uop_t u;
		u = make_uop(UNIT_ALU, base, off, 5'd0);
		u.wr_en = 1'b0;
		u.mem_write = 1'b1;
		u.mem_size = sz;
		u.store_data = data;
		add_row(u, 1'b0, 32'd0, 1'b0, 1'b0);
	endtask

	task automatic add_load(input mem_size_t sz, input logic [31:0] base,
		input logic [31:0] off, input logic [4:0] rd, input logic [31:0] exp);
		exe_uop_t u;
		u = make_uop(UNIT_ALU, base, off, rd);
		u.mem_read = 1'b1;
		u.mem_size = sz;
		u.wb_sel = WB_MEM;
		add_row(u, 1'b1, exp, 1'b0, 1'b0);
	endtask

	task automatic build_table();
		logic [31:0] w;
		logic [31:0] w2;
		exe_uop_t u;
		w = 32'h8c7f_e5a1;
		w2 = {w[31:16], 8'h5a, w[7:0]};
		add_alu(ADD, 32'd7, 32'd5, 5'd1);
		add_alu(SUB, 32'd3, 32'd10, 5'd2);
		add_alu(AND, 32'hf0f0_1234, 32'h0ff0_ff00, 5'd3);
		add_alu(OR, 32'hf000_0001, 32'h0000_0f10, 5'd4);
		add_alu(XOR, 32'haaaa_5555, 32'hffff_0000, 5'd5);
		// Shift amount 35 uses only its low five bits
		add_alu(SLL, 32'h0000_00f1, 32'd35, 5'd6);
		add_alu(SRL, 32'hf000_0010, 32'd4, 5'd7);
		add_alu(SRA, 32'hf000_0010, 32'd4, 5'd8);
		add_alu(SLT, 32'hffff_ffff, 32'd1, 5'd9);
		add_alu(SLTU, 32'hffff_ffff, 32'd1, 5'd10);
		add_div(DIV, -32'sd20, 32'd3, 5'd11, 1'b0, 1'b0);
		add_div(REM, -32'sd20, 32'd3, 5'd12, 1'b0, 1'b0);
		add_div(DIVU, 32'd100, 32'd7, 5'd13, 1'b0, 1'b0);
		add_div(REMU, 32'd100, 32'd7, 5'd14, 1'b0, 1'b0);
		add_div(DIV, 32'd20, -32'sd3, 5'd15, 1'b0, 1'b0);
		// Divide by zero
		add_div(DIV, 32'd5, 32'd0, 5'd16, 1'b0, 1'b0);
		add_div(REM, -32'sd9, 32'd0, 5'd17, 1'b0, 1'b0);
		add_div(DIVU, 32'd9, 32'd0, 5'd18, 1'b0, 1'b0);
		// Most negative over minus one
		add_div(DIV, 32'h8000_0000, 32'hffff_ffff, 5'd19, 1'b0, 1'b0);
		add_div(REM, 32'h8000_0000, 32'hffff_ffff, 5'd20, 1'b0, 1'b0);
		// ALU op queued behind a divide
		add_div(DIVU, 32'hffff_fff0, 32'd16, 5'd21, 1'b1, 1'b0);
		add_alu(ADD, 32'd40, 32'd2, 5'd22);
		add_store(LW, 32'h40, 32'd0, w);
		add_load(LB, 32'h40, 32'd0, 5'd23, load_model(LB, w, 2'd0));
		add_load(LBU, 32'h40, 32'd3, 5'd24, load_model(LBU, w, 2'd3));
		add_load(LH, 32'h40, 32'd2, 5'd25, load_model(LH, w, 2'd2));
		add_load(LHU, 32'h40, 32'd0, 5'd26, load_model(LHU, w, 2'd0));
		add_load(LW, 32'h40, 32'd0, 5'd27, w);
		add_store(LB, 32'h40, 32'd1, 32'h0000_005a);
		add_load(LW, 32'h40, 32'd0, 5'd28, w2);
		u = make_uop(UNIT_ALU, 32'd1, 32'd2, 5'd29);
		u.imm = 32'hffff_f800;
		u.wb_sel = WB_IMM;
		add_row(u, 1'b1, u.imm, 1'b0, 1'b0);
		u = make_uop(UNIT_ALU, 32'd1, 32'd2, 5'd30);
		u.pc4 = 32'h0000_1a04;
		u.wb_sel = WB_PC4;
		add_row(u, 1'b1, u.pc4, 1'b0, 1'b0);
		// Flushed divide, then a fresh divide and ALU op
		add_div(DIV, 32'd1000, 32'd7, 5'd31, 1'b0, 1'b1);
		add_div(DIV, 32'd1000, 32'd7, 5'd11, 1'b0, 1'b0);
		add_alu(XOR, 32'h1234_5678, 32'h0000_ffff, 5'd12);
	endtask

	// Edges spent with in_ready low
	task automatic wait_ready(output int lo);
		lo = 0;
		while (!in_ready) begin
			step(1);
			lo++;
			if (lo > WAIT_LIMIT) begin
				$display("Timeout waiting for in_ready to rise");
				stop_failed();
			end
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (pend_q.size() != 0) begin
			step(1);
			n++;
			if (n > WAIT_LIMIT) begin
				$display("Timeout waiting for wb_valid, %0d writebacks missing", pend_q.size());
				stop_failed();
			end
		end
	endtask

	task automatic run_row(input int i);
		row_t r;
		pend_t p;
		int lo;
		r = rows[i];
		in_uop = r.uop;
		in_valid = 1'b1;
		wait_ready(lo);
		// Acceptance edge
		@(posedge clk);
		#1;
		if (r.wb_exp) begin
			p.rd = r.rd;
			p.data = r.data;
			p.lat_chk = (r.uop.unit == UNIT_ALU);
			p.acc = cycle;
			pend_q.push_back(p);
		end
		in_valid = 1'b0;
		if (r.flush_op) begin
			step(5);
			flush = 1'b1;
			step(1);
			flush = 1'b0;
			check("in_ready", in_ready, 1'b1);
			// Window where a stale writeback would show up
			step(`DIV_STEPS + 4);
		end else if (r.uop.unit == UNIT_DIV) begin
			if (r.chain) begin
				in_uop = rows[i+1].uop;
				in_valid = 1'b1;
			end
			wait_ready(lo);
			check("in_ready low cycles", lo, `DIV_STEPS + 1);
		end
		if (!r.chain && !r.flush_op) begin
			if (r.wb_exp)
				wait_drain();
			else
				step(2);
			step($urandom_range(0, 3));
		end
	endtask

	// Writebacks leave in table order
	always @(negedge clk) begin : wb_monitor
		pend_t e;
		if (!rst && wb_valid) begin
			if (pend_q.size() == 0) begin
				$display("Writeback to rd %0d arrived with no op pending", wb.rd);
				stop_failed();
			end else begin
				e = pend_q.pop_front();
				check("wb.rd", wb.rd, e.rd);
				check("wb.data", wb.data, e.data);
				if (e.lat_chk)
					check("wb_valid latency", cycle - e.acc + 1, 2);
			end
		end
	end

	initial begin
		int idx;
		void'($urandom(29));
		rst = 1'b1;
		flush = 1'b0;
		in_valid = 1'b0;
		in_uop = '0;
		build_table();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		// Idle pipeline after reset
		repeat (4) begin
			check("in_ready", in_ready, 1'b1);
			check("wb_valid", wb_valid, 1'b0);
			step(1);
		end
		for (idx = 0; idx < rows.size(); idx++)
			run_row(idx);
		wait_drain();
		step(3);
		$display("All tests passed!");
		$finish;
	end

endmodule
